// File: Makefile
BIN  := obj_dir/Vtb_local_unit
SRCS := $(shell cat all.f)

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

$(BIN): all.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_local_unit -f all.f

clean:
	rm -rf obj_dir

// File: all.f
hw/noc_pkg.sv
hw/flit_fifo.sv
hw/traffic_gen.sv
hw/link_checker.sv
hw/node_monitor.sv
hw/local_unit.sv
testbench/local_unit_assertions.sv
testbench/tb_local_unit.sv

// File: hw/flit_fifo.sv
`timescale 1ns/1ps

module flit_fifo
    import noc_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  flit_t wr_data,
    input  logic  wr_en,
    input  logic  rd_en,
    output flit_t rd_data,
    output logic  empty
);

    flit_t mem [FIFO_DEPTH];

    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;

    logic do_write;
    logic do_read;

    // A read of an empty buffer and a write into a full one are dropped.
    assign do_write = wr_en && (count != (FIFO_AW + 1)'(FIFO_DEPTH));
    assign do_read  = rd_en && (count != '0);

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The head of the queue is always visible on the output.
    assign rd_data = mem[rd_ptr];
    assign empty   = (count == '0);

endmodule

// File: hw/link_checker.sv
`timescale 1ns/1ps

module link_checker
    import noc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  flit_t     flit,
    input  logic      valid,
    output seq_t      pckt_count,
    output err_code_t err_code,
    output logic      in_error
);

    check_state_t state;
    seq_t         flit_count;

    logic [TIMEOUT_W-1:0]   idle_count;
    logic [FLIT_TYPE_W-1:0] flit_type;

    assign flit_type = flit[FLIT_W-1 -: FLIT_TYPE_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            flit_count <= '0;
            pckt_count <= '0;
            idle_count <= '0;
            err_code   <= ERR_NONE;
        end else begin
            case (state)
                IDLE: begin
                    if (valid) begin
                        if (flit_type == HEAD_FLIT) begin
                            state      <= PACKET_RCVING;
                            flit_count <= 8'd1;
                            idle_count <= '0;
                        end else if (flit_type == SINGLE_FLIT) begin
                            pckt_count <= pckt_count + 1'b1;
                        end else begin
                            state    <= ERROR;
                            err_code <= ERR_FLIT_WRONG;
                        end
                    end
                end
                PACKET_RCVING: begin
                    if (valid) begin
                        idle_count <= '0;
                        if (flit_type == BODY_FLIT) begin
                            flit_count <= flit_count + 1'b1;
                        end else if (flit_type == TAIL_FLIT) begin
                            flit_count <= '0;
                            if (flit_count < PACKET_SIZE - 1) begin
                                state    <= ERROR;
                                err_code <= ERR_FLIT_MISSING;
                            end else if (flit_count > PACKET_SIZE - 1) begin
                                state    <= ERROR;
                                err_code <= ERR_FLIT_WRONG;
                            end else begin
                                state      <= IDLE;
                                pckt_count <= pckt_count + 1'b1;
                            end
                        end else begin
                            // A new packet started before this one closed.
                            state    <= ERROR;
                            err_code <= ERR_FLIT_MISSING;
                        end
                    end else begin
                        idle_count <= idle_count + 1'b1;
                        if (idle_count > TIMEOUT_W'(FLIT_TIMEOUT)) begin
                            state    <= ERROR;
                            err_code <= ERR_FLIT_TIMEOUT;
                        end
                    end
                end
                default: begin
                    state <= ERROR;
                end
            endcase
        end
    end

    assign in_error = (state == ERROR);

endmodule

// File: hw/local_unit.sv
`timescale 1ns/1ps

module local_unit
    import noc_pkg::*;
#(
    parameter coord_t cur_x = 3'd3
) (
    input  logic      clk,
    input  logic      rst,
    input  flit_t     eject_xpos,
    input  logic      eject_xpos_valid,
    input  flit_t     eject_xneg,
    input  logic      eject_xneg_valid,
    output flit_t     inject_xpos,
    output logic      inject_xpos_valid,
    input  logic      inject_xpos_avail,
    output flit_t     inject_xneg,
    output logic      inject_xneg_valid,
    input  logic      inject_xneg_avail,
    output logic      send_done,
    output logic      rcv_done,
    output logic      error,
    output err_code_t error_code
);

    seq_t      sent_count;
    seq_t      xpos_count;
    seq_t      xneg_count;
    err_code_t xpos_err;
    err_code_t xneg_err;
    logic      xpos_in_error;
    logic      xneg_in_error;

    traffic_gen #(
        .cur_x (cur_x)
    ) u_traffic_gen (
        .clk        (clk),
        .rst        (rst),
        .xpos_flit  (inject_xpos),
        .xpos_valid (inject_xpos_valid),
        .xpos_avail (inject_xpos_avail),
        .xneg_flit  (inject_xneg),
        .xneg_valid (inject_xneg_valid),
        .xneg_avail (inject_xneg_avail),
        .sent_count (sent_count)
    );

    link_checker u_xpos_checker (
        .clk        (clk),
        .rst        (rst),
        .flit       (eject_xpos),
        .valid      (eject_xpos_valid),
        .pckt_count (xpos_count),
        .err_code   (xpos_err),
        .in_error   (xpos_in_error)
    );

    link_checker u_xneg_checker (
        .clk        (clk),
        .rst        (rst),
        .flit       (eject_xneg),
        .valid      (eject_xneg_valid),
        .pckt_count (xneg_count),
        .err_code   (xneg_err),
        .in_error   (xneg_in_error)
    );

    node_monitor u_node_monitor (
        .clk           (clk),
        .rst           (rst),
        .sent_count    (sent_count),
        .xpos_count    (xpos_count),
        .xneg_count    (xneg_count),
        .xpos_err      (xpos_err),
        .xneg_err      (xneg_err),
        .xpos_in_error (xpos_in_error),
        .xneg_in_error (xneg_in_error),
        .send_done     (send_done),
        .rcv_done      (rcv_done),
        .error         (error),
        .error_code    (error_code)
    );

endmodule

// File: hw/noc_pkg.sv
package noc_pkg;

    // Flit format. The type field sits in the top bits of every flit.
    localparam int FLIT_W      = 32;
    localparam int FLIT_TYPE_W = 2;

    typedef logic [FLIT_W-1:0] flit_t;

    localparam logic [FLIT_TYPE_W-1:0] HEAD_FLIT   = 2'd0;
    localparam logic [FLIT_TYPE_W-1:0] BODY_FLIT   = 2'd1;
    localparam logic [FLIT_TYPE_W-1:0] TAIL_FLIT   = 2'd2;
    localparam logic [FLIT_TYPE_W-1:0] SINGLE_FLIT = 2'd3;

    // Ring size and node coordinate.
    localparam int XSIZE = 8;

    typedef logic [2:0] coord_t;

    // The head flit carries the type, dir, dst x, src x and sequence above this tag.
    localparam logic [14:0] HEAD_TAG = 15'h0EAD;

    localparam logic [FLIT_W-FLIT_TYPE_W-1:0] BODY_PAYLOAD = 30'h0000000D;
    localparam logic [FLIT_W-FLIT_TYPE_W-1:0] TAIL_PAYLOAD = 30'h00000A11;

    typedef logic [7:0] seq_t;

    // Traffic pattern.
    localparam int PACKET_SIZE   = 4;
    localparam int PACKET_NUM    = 3;
    localparam int INJECT_GAP    = 8;
    localparam int INJECT_PERIOD = INJECT_GAP + PACKET_SIZE;
    localparam int PERIOD_W      = $clog2(INJECT_PERIOD);
    localparam int FLIT_CNT_W    = $clog2(PACKET_SIZE);

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    localparam int FLIT_TIMEOUT = 16;
    localparam int TIMEOUT_W    = $clog2(FLIT_TIMEOUT + 2);

    typedef enum logic [1:0] {
        ERR_NONE,
        ERR_FLIT_WRONG,
        ERR_FLIT_MISSING,
        ERR_FLIT_TIMEOUT
    } err_code_t;

    typedef enum logic [1:0] {
        IDLE,
        PACKET_RCVING,
        ERROR
    } check_state_t;

endpackage

// File: hw/node_monitor.sv
`timescale 1ns/1ps

module node_monitor
    import noc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  seq_t      sent_count,
    input  seq_t      xpos_count,
    input  seq_t      xneg_count,
    input  err_code_t xpos_err,
    input  err_code_t xneg_err,
    input  logic      xpos_in_error,
    input  logic      xneg_in_error,
    output logic      send_done,
    output logic      rcv_done,
    output logic      error,
    output err_code_t error_code
);

    logic [8:0] rcv_total;

    // One bit wider so the sum of both links cannot wrap.
    assign rcv_total = {1'b0, xpos_count} + {1'b0, xneg_count};

    always_ff @(posedge clk) begin
        if (rst) begin
            send_done  <= 1'b0;
            rcv_done   <= 1'b0;
            error      <= 1'b0;
            error_code <= ERR_NONE;
        end else begin
            send_done <= (sent_count == PACKET_NUM);
            rcv_done  <= (rcv_total == 2 * PACKET_NUM);
            error     <= xpos_in_error || xneg_in_error;
            // The xpos link wins when both report.
            if (xpos_err != ERR_NONE) begin
                error_code <= xpos_err;
            end else begin
                error_code <= xneg_err;
            end
        end
    end

endmodule

// File: hw/traffic_gen.sv
`timescale 1ns/1ps

module traffic_gen
    import noc_pkg::*;
#(
    parameter coord_t cur_x = 3'd0
) (
    input  logic  clk,
    input  logic  rst,
    output flit_t xpos_flit,
    output logic  xpos_valid,
    input  logic  xpos_avail,
    output flit_t xneg_flit,
    output logic  xneg_valid,
    input  logic  xneg_avail,
    output seq_t  sent_count
);

    logic [PERIOD_W-1:0]   period_cnt;
    logic [FLIT_CNT_W-1:0] flit_cnt;
    logic                  wr_en;

    coord_t nxt_x;
    coord_t pre_x;

    flit_t xpos_build;
    flit_t xneg_build;

    logic xpos_empty;
    logic xneg_empty;

    function automatic flit_t build_flit(
        input logic                  dir,
        input coord_t                dst,
        input logic [FLIT_CNT_W-1:0] idx,
        input seq_t                  seq
    );
        flit_t f;
        if (idx == '0) begin
            f = {HEAD_FLIT, dir, dst, cur_x, seq, HEAD_TAG};
        end else if (idx == FLIT_CNT_W'(PACKET_SIZE - 1)) begin
            f = {TAIL_FLIT, TAIL_PAYLOAD};
        end else begin
            f = {BODY_FLIT, BODY_PAYLOAD};
        end
        return f;
    endfunction

    // The period counter free-runs; the last PACKET_SIZE slots of each period carry a packet.
    always_ff @(posedge clk) begin
        if (rst) begin
            period_cnt <= '0;
        end else if (period_cnt == PERIOD_W'(INJECT_PERIOD - 1)) begin
            period_cnt <= '0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    assign wr_en = (period_cnt >= PERIOD_W'(INJECT_GAP)) && (sent_count < PACKET_NUM);

    always_ff @(posedge clk) begin
        if (rst) begin
            flit_cnt   <= '0;
            sent_count <= '0;
        end else if (wr_en) begin
            if (flit_cnt == FLIT_CNT_W'(PACKET_SIZE - 1)) begin
                flit_cnt   <= '0;
                sent_count <= sent_count + 1'b1;
            end else begin
                flit_cnt <= flit_cnt + 1'b1;
            end
        end
    end

    // Neighbor coordinates wrap around the ring.
    assign nxt_x = (cur_x == coord_t'(XSIZE - 1)) ? '0 : cur_x + 1'b1;
    assign pre_x = (cur_x == '0) ? coord_t'(XSIZE - 1) : cur_x - 1'b1;

    assign xpos_build = build_flit(1'b0, nxt_x, flit_cnt, sent_count);
    assign xneg_build = build_flit(1'b1, pre_x, flit_cnt, sent_count);

    flit_fifo u_xpos_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_data (xpos_build),
        .wr_en   (wr_en),
        .rd_en   (xpos_avail),
        .rd_data (xpos_flit),
        .empty   (xpos_empty)
    );

    flit_fifo u_xneg_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_data (xneg_build),
        .wr_en   (wr_en),
        .rd_en   (xneg_avail),
        .rd_data (xneg_flit),
        .empty   (xneg_empty)
    );

    assign xpos_valid = ~xpos_empty;
    assign xneg_valid = ~xneg_empty;

endmodule

// File: testbench/local_unit_assertions.sv
`timescale 1ns/1ps

module local_unit_assertions
    import noc_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      inject_xpos_valid,
    input logic      inject_xneg_valid,
    input logic      error,
    input err_code_t error_code
);

    // Reset empties both FIFOs, so no flit is offered while it is held.
    inject_quiet_in_reset: assert property (
        @(posedge clk) $past(rst) |-> !inject_xpos_valid && !inject_xneg_valid
    ) else $error("inject valid high during reset");

    // The checkers only leave ERROR through reset.
    error_sticky: assert property (
        @(posedge clk) disable iff (rst) $past(error) |-> error
    ) else $error("error dropped without a reset");

    error_code_clean: assert property (
        @(posedge clk) disable iff (rst) !error |-> error_code == ERR_NONE
    ) else $error("error_code set while error is low");

endmodule

// File: testbench/tb_local_unit.sv
`timescale 1ns/1ps

module tb_local_unit
    import noc_pkg::*;
();

    // About 500 cycles cover all six tests, so this leaves a wide margin.
    localparam int     MAX_CYCLES = 3000;
    localparam int     RUN_FLITS  = PACKET_NUM * PACKET_SIZE;
    localparam coord_t NODE_X     = 3'd3;

    logic      clk;
    logic      rst;
    flit_t     eject_xpos;
    logic      eject_xpos_valid;
    flit_t     eject_xneg;
    logic      eject_xneg_valid;
    flit_t     inject_xpos;
    logic      inject_xpos_valid;
    logic      inject_xpos_avail;
    flit_t     inject_xneg;
    logic      inject_xneg_valid;
    logic      inject_xneg_avail;
    logic      send_done;
    logic      rcv_done;
    logic      error;
    err_code_t error_code;

    int          errors;
    int          tests_run;
    int          test_fails;
    int          cycles;
    logic [31:0] lfsr_state;

    local_unit #(
        .cur_x (NODE_X)
    ) i_dut (
        .clk               (clk),
        .rst               (rst),
        .eject_xpos        (eject_xpos),
        .eject_xpos_valid  (eject_xpos_valid),
        .eject_xneg        (eject_xneg),
        .eject_xneg_valid  (eject_xneg_valid),
        .inject_xpos       (inject_xpos),
        .inject_xpos_valid (inject_xpos_valid),
        .inject_xpos_avail (inject_xpos_avail),
        .inject_xneg       (inject_xneg),
        .inject_xneg_valid (inject_xneg_valid),
        .inject_xneg_avail (inject_xneg_avail),
        .send_done         (send_done),
        .rcv_done          (rcv_done),
        .error             (error),
        .error_code        (error_code)
    );

    bind local_unit local_unit_assertions i_assertions (
        .clk               (clk),
        .rst               (rst),
        .inject_xpos_valid (inject_xpos_valid),
        .inject_xneg_valid (inject_xneg_valid),
        .error             (error),
        .error_code        (error_code)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped: no result after %0d cycles.", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1, stepped once per bit taken.
    function automatic int random_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            r = (r << 1) | int'(lfsr_state[0]);
        end
        return r;
    endfunction

    // Flit idx of packet pkt as the node at x = 3 must send it.
    function automatic flit_t expected_flit(input logic dir, input int pkt, input int idx);
        flit_t  f;
        coord_t dst;
        dst = dir ? coord_t'((NODE_X + XSIZE - 1) % XSIZE) : coord_t'((NODE_X + 1) % XSIZE);
        if (idx == 0) begin
            f = {2'd0, dir, dst, NODE_X, 8'(pkt), 15'h0EAD};
        end else if (idx == PACKET_SIZE - 1) begin
            f = {2'd2, 30'h00000A11};
        end else begin
            f = {2'd1, 30'h0000000D};
        end
        return f;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("Error at %0t ns: %s.", $time, msg);
        errors++;
    endtask

    task automatic end_test(input string name, input int start);
        tests_run++;
        if (errors != start) begin
            test_fails++;
            $display("Test %s: failed with %0d errors", name, errors - start);
        end else begin
            $display("Test %s: passed", name);
        end
    endtask

    task automatic drive_idle();
        eject_xpos       = '0;
        eject_xpos_valid = 1'b0;
        eject_xneg       = '0;
        eject_xneg_valid = 1'b0;
    endtask

    task automatic reset_dut();
        @(posedge clk);
        #1;
        rst = 1'b1;
        drive_idle();
        inject_xpos_avail = 1'b0;
        inject_xneg_avail = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Holds one flit on an eject link for a single cycle.
    task automatic send_flit(input logic dir, input flit_t flit);
        if (dir) begin
            eject_xneg       = flit;
            eject_xneg_valid = 1'b1;
        end else begin
            eject_xpos       = flit;
            eject_xpos_valid = 1'b1;
        end
        idle_cycles(1);
        drive_idle();
    endtask

    task automatic send_packet(input logic dir, input int pkt);
        for (int idx = 0; idx < PACKET_SIZE; idx++) begin
            send_flit(dir, expected_flit(dir, pkt, idx));
            idle_cycles(random_bits(3));
        end
    endtask

    task automatic wait_flag(input logic want_error, input string what);
        int waited;
        waited = 0;
        while (((want_error ? error : rcv_done) !== 1'b1) && waited < 40) begin
            @(negedge clk);
            waited++;
        end
        if ((want_error ? error : rcv_done) !== 1'b1) begin
            report_problem({what, " never went high"});
        end
    endtask

    task automatic take_flit(input logic dir, input flit_t flit, inout int n);
        if (n >= RUN_FLITS) begin
            report_problem(dir ? "extra flit on inject_xneg" : "extra flit on inject_xpos");
        end else begin
            check_value(dir ? "inject_xneg" : "inject_xpos", flit,
                        expected_flit(dir, n / PACKET_SIZE, n % PACKET_SIZE));
        end
        n++;
    endtask

    task automatic test_reset_state();
        int start;
        start = errors;
        reset_dut();
        @(negedge clk);
        check_value("inject_xpos_valid", inject_xpos_valid, 0);
        check_value("inject_xneg_valid", inject_xneg_valid, 0);
        check_value("send_done", send_done, 0);
        check_value("rcv_done", rcv_done, 0);
        check_value("error", error, 0);
        check_value("error_code", error_code, ERR_NONE);
        end_test("reset_state", start);
    endtask

    // With stall set, each avail follows one LFSR bit per cycle.
    task automatic run_stream(input string name, input logic stall);
        int start;
        int pos_n;
        int neg_n;
        int waited;
        start  = errors;
        pos_n  = 0;
        neg_n  = 0;
        waited = 0;
        reset_dut();
        while ((pos_n < RUN_FLITS || neg_n < RUN_FLITS) && waited < 400) begin
            @(posedge clk);
            #1;
            inject_xpos_avail = stall ? 1'(random_bits(1)) : 1'b1;
            inject_xneg_avail = stall ? 1'(random_bits(1)) : 1'b1;
            @(negedge clk);
            if (inject_xpos_valid && inject_xpos_avail) begin
                take_flit(1'b0, inject_xpos, pos_n);
            end
            if (inject_xneg_valid && inject_xneg_avail) begin
                take_flit(1'b1, inject_xneg, neg_n);
            end
            waited++;
        end
        if (waited >= 400) begin
            report_problem("inject links stopped before all flits were sent");
        end
        @(negedge clk);
        check_value("inject_xpos_valid", inject_xpos_valid, 0);
        check_value("inject_xneg_valid", inject_xneg_valid, 0);
        check_value("send_done", send_done, 1);
        end_test(name, start);
    endtask

    task automatic test_reception();
        int start;
        start = errors;
        reset_dut();
        for (int d = 0; d < 2; d++) begin
            send_packet(d[0], 0);
            send_packet(d[0], 1);
            send_flit(d[0], {2'd3, 30'h0});
        end
        wait_flag(1'b0, "rcv_done");
        check_value("error", error, 0);
        end_test("reception", start);
    endtask

    task automatic test_malformed();
        int start;
        start = errors;
        reset_dut();
        send_flit(1'b0, expected_flit(1'b0, 0, 0));
        send_flit(1'b0, expected_flit(1'b0, 0, 1));
        send_flit(1'b0, expected_flit(1'b0, 0, PACKET_SIZE - 1));
        wait_flag(1'b1, "error after a short packet");
        check_value("error_code", error_code, ERR_FLIT_MISSING);
        reset_dut();
        send_flit(1'b1, expected_flit(1'b1, 0, 1));
        wait_flag(1'b1, "error after a body flit in idle");
        check_value("error_code", error_code, ERR_FLIT_WRONG);
        end_test("malformed", start);
    endtask

    task automatic test_stall();
        int start;
        start = errors;
        reset_dut();
        send_flit(1'b0, expected_flit(1'b0, 0, 0));
        idle_cycles(FLIT_TIMEOUT + 5);
        @(negedge clk);
        check_value("error", error, 1);
        check_value("error_code", error_code, ERR_FLIT_TIMEOUT);
        end_test("stall", start);
    endtask

    initial begin
        rst               = 1'b1;
        inject_xpos_avail = 1'b0;
        inject_xneg_avail = 1'b0;
        errors            = 0;
        tests_run         = 0;
        test_fails        = 0;
        cycles            = 0;
        lfsr_state        = 32'h620f;
        drive_idle();
        test_reset_state();
        run_stream("injection_format", 1'b0);
        run_stream("back_pressure", 1'b1);
        test_reception();
        test_malformed();
        test_stall();
        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, test_fails, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
